/* design/mm_fixed_pkg.sv */
// ####################
// Q8.8 fixed-point number format
// ####################

package mm_fixed_pkg;

    // Element width and fraction bits
    localparam int data_w = 16;
    localparam int frac_w = 8;

    // Full product before the shift
    localparam int prod_w = 2 * data_w;

    // One matrix element, also the accumulator type
    typedef logic signed [data_w-1:0] fixed_t;

    typedef logic signed [prod_w-1:0] prod_t;

    // Q8.8 multiply
    // Keeps the middle bits, same as an arithmetic shift by frac_w then truncation
    function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
        prod_t p;
        p = a * b;
        return p[frac_w +: data_w];
    endfunction

endpackage

/* design/mm_array_pkg.sv */
// ####################
// Array geometry, buses and controller states
// ####################

package mm_array_pkg;

    import mm_fixed_pkg::*;

    // Rows and columns of the PE grid
    localparam int array_n = 4;

    // One operand step per inner-product term
    localparam int feed_steps = array_n;

    // Two skew hops of array_n-1, the PE stages fold into the final edge
    localparam int drain_cycles = 2 * (array_n - 1);

    // Shared counter for feed and drain
    typedef logic [$clog2(drain_cycles)-1:0] step_t;

    // Row or column index inside the grid
    typedef logic [$clog2(array_n)-1:0] idx_t;

    // Row-major, elem[0][0] sits at the top bits
    typedef struct packed {
        fixed_t [0:array_n-1][0:array_n-1] elem;
    } mat_t;

    // One feed step along an edge of the array
    typedef struct packed {
        fixed_t [0:array_n-1] lane;
    } vec_t;

    typedef enum logic [1:0] {
        st_idle,
        st_clear,
        st_feed,
        st_drain
    } ctrl_state_t;

endpackage

/* design/mac_pe.sv */
// ####################
// Systolic PE, passes operands on and accumulates
// ####################

`timescale 1ns/1ps

module mac_pe
    import mm_fixed_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   clear,
    input  fixed_t in_west,
    input  fixed_t in_north,
    output fixed_t out_east,
    output fixed_t out_south,
    output fixed_t acc
);

    fixed_t term;

    // Truncated Q8.8 product of the operands arriving this cycle
    assign term = fx_mul(in_west, in_north);

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            out_east  <= '0;
            out_south <= '0;
            acc       <= '0;
        end else begin
            // One hop per cycle to the neighbours
            out_east  <= in_west;
            out_south <= in_north;
            // Wraps on overflow
            acc       <= acc + term;
        end
    end

endmodule

/* design/systolic_array.sv */
// ####################
// 4x4 output-stationary grid of MAC PEs
// ####################

`timescale 1ns/1ps

module systolic_array
    import mm_fixed_pkg::*;
    import mm_array_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  vec_t west_edge,
    input  vec_t north_edge,
    output mat_t result
);

    // Column 0 and row 0 come from the edges
    // The extra column and row hang off the east and south sides
    fixed_t h_net [array_n][array_n+1];
    fixed_t v_net [array_n+1][array_n];

    for (genvar i = 0; i < array_n; i++) begin : g_edge
        assign h_net[i][0] = west_edge.lane[i];
        assign v_net[0][i] = north_edge.lane[i];
    end

    for (genvar i = 0; i < array_n; i++) begin : g_row
        for (genvar j = 0; j < array_n; j++) begin : g_col
            mac_pe u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .clear     (clear),
                .in_west   (h_net[i][j]),
                .in_north  (v_net[i][j]),
                .out_east  (h_net[i][j+1]),
                .out_south (v_net[i+1][j]),
                .acc       (result.elem[i][j])
            );
        end
    end

endmodule

/* design/operand_skew.sv */
// ####################
// Triangular delay lines for both array edges
// ####################

`timescale 1ns/1ps

module operand_skew
    import mm_fixed_pkg::*;
    import mm_array_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  vec_t west_vec,
    input  vec_t north_vec,
    output vec_t west_edge,
    output vec_t north_edge
);

    for (genvar i = 0; i < array_n; i++) begin : g_lane
        if (i == 0) begin : g_direct
            // Corner lane goes straight in
            assign west_edge.lane[i]  = west_vec.lane[i];
            assign north_edge.lane[i] = north_vec.lane[i];
        end else begin : g_delay
            // Lane i is i registers deep, slot 0 is the newest
            fixed_t west_q  [i];
            fixed_t north_q [i];

            always_ff @(posedge clk) begin
                if (!rst_n || clear) begin
                    west_q  <= '{default: '0};
                    north_q <= '{default: '0};
                end else begin
                    west_q[0]  <= west_vec.lane[i];
                    north_q[0] <= north_vec.lane[i];
                    for (int d = 1; d < i; d++) begin
                        west_q[d]  <= west_q[d-1];
                        north_q[d] <= north_q[d-1];
                    end
                end
            end

            assign west_edge.lane[i]  = west_q[i-1];
            assign north_edge.lane[i] = north_q[i-1];
        end
    end

endmodule

/* design/mm_controller.sv */
// ####################
// Sequencer for clear, feed and drain
// ####################

`timescale 1ns/1ps

module mm_controller
    import mm_array_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  mat_t a_mat,
    input  mat_t b_mat,
    output logic clear_acc,
    output logic feed_en,
    output logic busy,
    output logic done,
    output vec_t west_vec,
    output vec_t north_vec
);

    ctrl_state_t state;
    step_t       step;
    idx_t        k;
    logic        accept;
    mat_t        a_lat;
    mat_t        b_lat;

    // No new product until the done cycle has passed
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            step  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_clear;
                    end
                end
                st_clear: begin
                    state <= st_feed;
                    step  <= '0;
                end
                st_feed: begin
                    if (step == step_t'(feed_steps - 1)) begin
                        state <= st_drain;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                st_drain: begin
                    // Last PE takes its final pair in the last drain cycle
                    if (step == step_t'(drain_cycles - 1)) begin
                        state <= st_idle;
                        step  <= '0;
                        done  <= 1'b1;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Operands captured on the accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            a_lat <= a_mat;
            b_lat <= b_mat;
        end
    end

    assign clear_acc = (state == st_clear);
    assign feed_en   = (state == st_feed);
    assign busy      = (state != st_idle) || done;

    assign k = idx_t'(step);

    // Step k: column k of A to the west, row k of B to the north
    always_comb begin
        west_vec  = '0;
        north_vec = '0;
        if (feed_en) begin
            for (int i = 0; i < array_n; i++) begin
                west_vec.lane[i]  = a_lat.elem[i][k];
                north_vec.lane[i] = b_lat.elem[k][i];
            end
        end
    end

endmodule

/* design/matmul_top.sv */
// ####################
// 4x4 Q8.8 systolic matrix multiplier
// ####################

`timescale 1ns/1ps

module matmul_top
    import mm_array_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  mat_t a_mat,
    input  mat_t b_mat,
    output logic busy,
    output logic done,
    output mat_t c_mat
);

    logic clear_acc;
    vec_t west_vec;
    vec_t north_vec;
    vec_t west_edge;
    vec_t north_edge;

    mm_controller u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .a_mat     (a_mat),
        .b_mat     (b_mat),
        .clear_acc (clear_acc),
        .feed_en   (),
        .busy      (busy),
        .done      (done),
        .west_vec  (west_vec),
        .north_vec (north_vec)
    );

    operand_skew u_skew (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear_acc),
        .west_vec   (west_vec),
        .north_vec  (north_vec),
        .west_edge  (west_edge),
        .north_edge (north_edge)
    );

    systolic_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear_acc),
        .west_edge  (west_edge),
        .north_edge (north_edge),
        .result     (c_mat)
    );

endmodule

/* bench/matmul_ref.svh */
// ####################
// Reference model for the Q8.8 matrix product
// ####################

`ifndef MATMUL_REF_SVH
`define MATMUL_REF_SVH

// Each term is the full product shifted right by the fraction bits
// and cut to one element, the running sum wraps at the element width
function automatic mat_t matmul_ref(input mat_t a, input mat_t b);
    mat_t   c;
    int     a_val;
    int     b_val;
    int     full;
    int     term;
    fixed_t sum;
    c = '0;
    for (int i = 0; i < array_n; i++) begin
        for (int j = 0; j < array_n; j++) begin
            sum = '0;
            for (int k = 0; k < array_n; k++) begin
                a_val = $signed(a.elem[i][k]);
                b_val = $signed(b.elem[k][j]);
                // Fits in 32 bits for two 16-bit operands
                full  = a_val * b_val;
                term  = full >>> frac_w;
                sum   = sum + fixed_t'(term);
            end
            c.elem[i][j] = sum;
        end
    end
    return c;
endfunction

`endif

/* bench/matmul_tb.sv */
// ####################
// Testbench for the 4x4 Q8.8 matrix multiplier
// ####################

`timescale 1ns/1ps

module matmul_tb
    import mm_fixed_pkg::*;
    import mm_array_pkg::*;
();

    localparam int num_rand     = 12;
    localparam int num_products = 4 + 2 * num_rand;
    localparam int done_latency = 12;
    localparam int hold_cycles  = 6;
    // Roughly 20 cycles per product plus reset and idle stretches
    localparam int cycle_limit  = num_products * 20 + 100;

    logic clk;
    logic rst_n;
    logic start;
    mat_t a_mat;
    mat_t b_mat;
    logic busy;
    logic done;
    mat_t c_mat;

    integer seed;
    mat_t   exp_c;
    int     started     = 0;
    int     compared    = 0;
    int     cycle_count = 0;

    `include "matmul_ref.svh"

    matmul_top dut (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .a_mat (a_mat),
        .b_mat (b_mat),
        .busy  (busy),
        .done  (done),
        .c_mat (c_mat)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            fail_now("value check failed");
        end
    endtask

    task automatic check_matrix(input string name, input mat_t got, input mat_t exp);
        for (int i = 0; i < array_n; i++) begin
            for (int j = 0; j < array_n; j++) begin
                check($sformatf("%s[%0d][%0d]", name, i, j),
                      32'(got.elem[i][j]), 32'(exp.elem[i][j]));
            end
        end
    endtask

    // Narrow values stay within about four in magnitude
    function automatic mat_t random_mat(input bit narrow);
        mat_t m;
        int   v;
        for (int i = 0; i < array_n; i++) begin
            for (int j = 0; j < array_n; j++) begin
                v = $random(seed);
                if (narrow) begin
                    m.elem[i][j] = fixed_t'(v % 1024);
                end else begin
                    m.elem[i][j] = fixed_t'(v);
                end
            end
        end
        return m;
    endfunction

    function automatic mat_t scaled_identity(input fixed_t diag);
        mat_t m;
        m = '0;
        for (int i = 0; i < array_n; i++) begin
            m.elem[i][i] = diag;
        end
        return m;
    endfunction

    // One product from the start pulse to the cycle after done
    task automatic run_product(input mat_t a, input mat_t b, input int extra_start_at);
        int cycles;
        exp_c   = matmul_ref(a, b);
        a_mat   = a;
        b_mat   = b;
        start   = 1'b1;
        started = started + 1;
        cycles  = 0;
        do begin
            @(negedge clk);
            cycles = cycles + 1;
            check("busy", 32'(busy), 32'd1);
            if (cycles == extra_start_at) begin
                // Ignored while busy so new operands must not leak in
                start = 1'b1;
                a_mat = random_mat(1'b0);
                b_mat = random_mat(1'b0);
            end else begin
                start = 1'b0;
                a_mat = mat_t'(~a);
                b_mat = mat_t'(~b);
            end
            if (cycles > 2 * done_latency) begin
                fail_now("done did not arrive after start");
            end
        end while (!done);
        start = 1'b0;
        check("done latency", 32'(cycles), 32'(done_latency));
        @(negedge clk);
        check("done", 32'(done), 32'd0);
        check("busy", 32'(busy), 32'd0);
    endtask

    task automatic check_hold(input int n);
        repeat (n) begin
            @(negedge clk);
            check("done", 32'(done), 32'd0);
            check_matrix("c_mat", c_mat, exp_c);
        end
    endtask

    // Result check on every done pulse
    always @(negedge clk) begin
        if (rst_n && done) begin
            check_matrix("c_mat", c_mat, exp_c);
            compared = compared + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_now($sformatf("timeout, no finish after %0d cycles", cycle_count));
        end
    end

    initial begin : stimulus
        mat_t a;
        mat_t b;
        seed  = 32'ha8a6;
        rst_n = 1'b0;
        start = 1'b0;
        a_mat = '0;
        b_mat = '0;
        exp_c = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("busy", 32'(busy), 32'd0);
        check("done", 32'(done), 32'd0);
        check_matrix("c_mat", c_mat, '0);

        // A times the identity gives A back
        a = random_mat(1'b0);
        run_product(a, scaled_identity(16'h0100), 0);
        check_matrix("c_mat", c_mat, a);

        // 2.0 times the identity doubles B with wrap
        b = random_mat(1'b0);
        run_product(scaled_identity(16'h0200), b, 0);
        for (int i = 0; i < array_n; i++) begin
            for (int j = 0; j < array_n; j++) begin
                a.elem[i][j] = fixed_t'(2 * int'($signed(b.elem[i][j])));
            end
        end
        check_matrix("c_mat", c_mat, a);

        check_hold(hold_cycles);

        // Start pulses while busy
        run_product(random_mat(1'b0), random_mat(1'b0), 4);
        run_product(random_mat(1'b1), random_mat(1'b1), 11);

        // Back to back with full range then narrow values
        for (int t = 0; t < num_rand; t++) begin
            run_product(random_mat(1'b0), random_mat(1'b0), 0);
        end
        for (int t = 0; t < num_rand; t++) begin
            run_product(random_mat(1'b1), random_mat(1'b1), 0);
        end

        @(negedge clk);
        check("done count", 32'(compared), 32'(started));
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* build.f */
+incdir+bench
design/mm_fixed_pkg.sv
design/mm_array_pkg.sv
design/mac_pe.sv
design/systolic_array.sv
design/operand_skew.sv
design/mm_controller.sv
design/matmul_top.sv
bench/matmul_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = matmul_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = === FAIL ===
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exit code is ignored here, the log decides
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q -F "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
